// ==== hdl/roc_pkg.sv ====
// ##################################################
// Read-only cache shared definitions
// Widths, cache geometry, route and response codes
// ##################################################

`default_nettype none

package roc_pkg;

  // Request and data widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;

  // Direct-mapped geometry, one word per line
  localparam int unsigned LINE_COUNT = 16;
  localparam int unsigned INDEX_W    = $clog2(LINE_COUNT);
  localparam int unsigned OFFSET_W   = 2;
  localparam int unsigned TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

  // Addresses from here upward have no target
  localparam logic [ADDR_W-1:0] DECODE_LIMIT = 16'hF000;

  // Where a request is sent after decode
  typedef enum logic [1:0] {
    ROUTE_ERROR  = 2'd0,
    ROUTE_CACHE  = 2'd1,
    ROUTE_BYPASS = 2'd2
  } route_e;

  // Response codes, AXI style encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage

`default_nettype wire

// ==== hdl/roc_req_if.sv ====
// ##################################################
// Routed request from address decode to lookup
// ##################################################

`timescale 1ns/1ps
`default_nettype none

interface roc_req_if;

  logic                          valid;
  logic [roc_pkg::ADDR_W-1:0]    addr;
  logic [roc_pkg::ID_W-1:0]      id;
  roc_pkg::route_e               route;
  // Response handshake completed
  logic                          done;

  modport decode (output valid, addr, id, route, input done);

  modport lookup (input valid, addr, id, route);

endinterface

`default_nettype wire

// ==== hdl/roc_fill_if.sv ====
// ##################################################
// Fill path between lookup and refill
// Memory read request and its returned word
// ##################################################

`timescale 1ns/1ps
`default_nettype none

interface roc_fill_if;

  logic                          req_valid;
  logic                          req_ready;
  logic [roc_pkg::ADDR_W-1:0]    req_addr;
  // Word may be stored in the line
  logic                          req_cache;

  // Single cycle strobe, never stalled
  logic                          rsp_valid;
  logic [roc_pkg::DATA_W-1:0]    rsp_data;
  logic                          rsp_error;

  modport lookup (
    output req_valid, req_addr, req_cache,
    input  req_ready, rsp_valid, rsp_data, rsp_error
  );

  modport refill (
    input  req_valid, req_addr,
    output req_ready, rsp_valid, rsp_data, rsp_error
  );

endinterface

`default_nettype wire

// ==== hdl/roc_addr_decode.sv ====
// ##################################################
// Address decode for the read-only cache
// Routes each request and holds it until done
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module roc_addr_decode (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic                       req_valid_i,
  output logic                            req_ready_o,
  input  wire logic [roc_pkg::ADDR_W-1:0] req_addr_i,
  input  wire logic [roc_pkg::ID_W-1:0]   req_id_i,
  input  wire logic [roc_pkg::ADDR_W-1:0] win_start_i,
  input  wire logic [roc_pkg::ADDR_W-1:0] win_end_i,
  roc_req_if.decode                       req
);

  logic                       init_q;
  logic                       busy_q;
  logic                       accept;
  roc_pkg::route_e            route_d;
  roc_pkg::route_e            route_q;
  logic [roc_pkg::ADDR_W-1:0] addr_q;
  logic [roc_pkg::ID_W-1:0]   id_q;

  // Error has priority over the window
  always_comb begin
    if (req_addr_i >= roc_pkg::DECODE_LIMIT) begin
      route_d = roc_pkg::ROUTE_ERROR;
    end else if (req_addr_i >= win_start_i && req_addr_i <= win_end_i) begin
      route_d = roc_pkg::ROUTE_CACHE;
    end else begin
      route_d = roc_pkg::ROUTE_BYPASS;
    end
  end

  // Not ready in the first cycle out of reset
  assign req_ready_o = init_q & ~busy_q;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      init_q <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      init_q <= 1'b1;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (req.done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= req_addr_i;
      id_q    <= req_id_i;
      route_q <= route_d;
    end
  end

  assign req.valid = busy_q;
  assign req.addr  = addr_q;
  assign req.id    = id_q;
  assign req.route = route_q;

endmodule

`default_nettype wire

// ==== hdl/roc_lookup.sv ====
// ##################################################
// Cache lookup and request sequencing
// Tag, valid and data arrays, hit check, flush
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module roc_lookup (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  flush_valid_i,
  output logic                       flush_ready_o,
  roc_req_if.lookup                  req,
  roc_fill_if.lookup                 fill,
  output logic                       load_o,
  output logic [roc_pkg::ID_W-1:0]   load_id_o,
  output logic [roc_pkg::DATA_W-1:0] load_data_o,
  output roc_pkg::resp_e             load_resp_o,
  input  wire logic                  done_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CHECK,
    ST_FILL,
    ST_RESP
  } state_e;

  state_e                              state_q;
  state_e                              state_d;
  logic [roc_pkg::TAG_W-1:0]           tag_q  [roc_pkg::LINE_COUNT];
  logic [roc_pkg::DATA_W-1:0]          data_q [roc_pkg::LINE_COUNT];
  logic [roc_pkg::LINE_COUNT-1:0]      valid_q;
  logic [roc_pkg::INDEX_W-1:0]         req_idx;
  logic [roc_pkg::TAG_W-1:0]           req_tag;
  logic                                hit;
  logic                                fill_valid;
  logic                                line_write;

  assign req_idx = req.addr[roc_pkg::OFFSET_W +: roc_pkg::INDEX_W];
  assign req_tag = req.addr[roc_pkg::ADDR_W-1 -: roc_pkg::TAG_W];
  assign hit     = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

  always_comb begin
    state_d     = state_q;
    load_o      = 1'b0;
    load_data_o = '0;
    load_resp_o = roc_pkg::RESP_OKAY;
    fill_valid  = 1'b0;
    case (state_q)
      // Route and hit are decided in the arrival cycle
      ST_IDLE: begin
        if (req.valid) begin
          if (req.route == roc_pkg::ROUTE_ERROR) begin
            load_o      = 1'b1;
            load_resp_o = roc_pkg::RESP_DECERR;
            state_d     = ST_RESP;
          end else if (req.route == roc_pkg::ROUTE_CACHE && hit) begin
            load_o      = 1'b1;
            load_data_o = data_q[req_idx];
            state_d     = ST_RESP;
          end else begin
            fill_valid = 1'b1;
            state_d    = fill.req_ready ? ST_FILL : ST_CHECK;
          end
        end
      end
      // Miss checked, refill has not taken it yet
      ST_CHECK: begin
        fill_valid = 1'b1;
        if (fill.req_ready) begin
          state_d = ST_FILL;
        end
      end
      ST_FILL: begin
        if (fill.rsp_valid) begin
          load_o      = 1'b1;
          load_data_o = fill.rsp_data;
          load_resp_o = fill.rsp_error ? roc_pkg::RESP_SLVERR : roc_pkg::RESP_OKAY;
          state_d     = ST_RESP;
        end
      end
      ST_RESP: begin
        if (done_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  assign fill.req_valid = fill_valid;
  assign fill.req_addr  = req.addr;
  assign fill.req_cache = (req.route == roc_pkg::ROUTE_CACHE);
  assign load_id_o      = req.id;
  assign flush_ready_o  = (state_q == ST_IDLE) & ~req.valid;

  // Failed or uncached reads leave the line alone
  assign line_write = (state_q == ST_FILL) && fill.rsp_valid && fill.req_cache
                      && !fill.rsp_error;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      valid_q <= '0;
    end else begin
      state_q <= state_d;
      if (flush_valid_i && flush_ready_o) begin
        valid_q <= '0;
      end else if (line_write) begin
        valid_q[req_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (line_write) begin
      tag_q[req_idx]  <= req_tag;
      data_q[req_idx] <= fill.rsp_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/roc_refill.sv ====
// ##################################################
// Refill engine toward backing memory
// One outstanding word read at a time
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module roc_refill (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  roc_fill_if.refill                      fill,
  output logic                            mem_req_valid_o,
  input  wire logic                       mem_req_ready_i,
  output logic [roc_pkg::ADDR_W-1:0]      mem_req_addr_o,
  input  wire logic                       mem_rsp_valid_i,
  input  wire logic [roc_pkg::DATA_W-1:0] mem_rsp_data_i,
  input  wire logic                       mem_rsp_error_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_e;

  state_e                     state_q;
  logic [roc_pkg::ADDR_W-1:0] addr_q;
  logic                       fill_accept;

  assign fill.req_ready = (state_q == ST_IDLE);
  assign fill_accept    = fill.req_valid & fill.req_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (fill_accept) begin
            state_q <= ST_REQ;
          end
        end
        // Held until memory takes it
        ST_REQ: begin
          if (mem_req_ready_i) begin
            state_q <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (mem_rsp_valid_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Word aligned copy of the fill address
  always_ff @(posedge clk_i) begin
    if (fill_accept) begin
      addr_q <= {fill.req_addr[roc_pkg::ADDR_W-1:roc_pkg::OFFSET_W],
                 {roc_pkg::OFFSET_W{1'b0}}};
    end
  end

  assign mem_req_valid_o = (state_q == ST_REQ);
  assign mem_req_addr_o  = addr_q;

  // Memory response goes straight back
  assign fill.rsp_valid = (state_q == ST_WAIT) & mem_rsp_valid_i;
  assign fill.rsp_data  = mem_rsp_data_i;
  assign fill.rsp_error = mem_rsp_error_i;

endmodule

`default_nettype wire

// ==== hdl/roc_resp_stage.sv ====
// ##################################################
// Response holding register
// Keeps one response stable under back-pressure
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module roc_resp_stage (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic                       load_i,
  input  wire logic [roc_pkg::ID_W-1:0]   load_id_i,
  input  wire logic [roc_pkg::DATA_W-1:0] load_data_i,
  input  wire roc_pkg::resp_e             load_resp_i,
  output logic                            done_o,
  output logic                            rsp_valid_o,
  input  wire logic                       rsp_ready_i,
  output logic [roc_pkg::ID_W-1:0]        rsp_id_o,
  output logic [roc_pkg::DATA_W-1:0]      rsp_data_o,
  output roc_pkg::resp_e                  rsp_resp_o
);

  logic                       valid_q;
  logic [roc_pkg::ID_W-1:0]   id_q;
  logic [roc_pkg::DATA_W-1:0] data_q;
  roc_pkg::resp_e             resp_q;

  // Handshake completes the request
  assign done_o = valid_q & rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (load_i) begin
      valid_q <= 1'b1;
    end else if (done_o) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      id_q   <= load_id_i;
      data_q <= load_data_i;
      resp_q <= load_resp_i;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_id_o    = id_q;
  assign rsp_data_o  = data_q;
  assign rsp_resp_o  = resp_q;

endmodule

`default_nettype wire

// ==== hdl/roc_top.sv ====
// ##################################################
// Read-only cache subsystem top level
// Decode, lookup, refill and response stage
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module roc_top (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  // Request
  input  wire logic                       req_valid_i,
  output logic                            req_ready_o,
  input  wire logic [roc_pkg::ADDR_W-1:0] req_addr_i,
  input  wire logic [roc_pkg::ID_W-1:0]   req_id_i,
  // Response
  output logic                            rsp_valid_o,
  input  wire logic                       rsp_ready_i,
  output logic [roc_pkg::ID_W-1:0]        rsp_id_o,
  output logic [roc_pkg::DATA_W-1:0]      rsp_data_o,
  output roc_pkg::resp_e                  rsp_resp_o,
  // Backing memory
  output logic                            mem_req_valid_o,
  input  wire logic                       mem_req_ready_i,
  output logic [roc_pkg::ADDR_W-1:0]      mem_req_addr_o,
  input  wire logic                       mem_rsp_valid_i,
  input  wire logic [roc_pkg::DATA_W-1:0] mem_rsp_data_i,
  input  wire logic                       mem_rsp_error_i,
  // Cacheable window, bounds inclusive
  input  wire logic [roc_pkg::ADDR_W-1:0] win_start_i,
  input  wire logic [roc_pkg::ADDR_W-1:0] win_end_i,
  input  wire logic                       flush_valid_i,
  output logic                            flush_ready_o
);

  logic                       load;
  logic [roc_pkg::ID_W-1:0]   load_id;
  logic [roc_pkg::DATA_W-1:0] load_data;
  roc_pkg::resp_e             load_resp;
  logic                       resp_done;

  roc_req_if  req_if ();
  roc_fill_if fill_if ();

  // Completion goes back to decode and lookup alike
  assign req_if.done = resp_done;

  roc_addr_decode i_decode (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_addr_i  ( req_addr_i  ),
    .req_id_i    ( req_id_i    ),
    .win_start_i ( win_start_i ),
    .win_end_i   ( win_end_i   ),
    .req         ( req_if      )
  );

  roc_lookup i_lookup (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .flush_valid_i ( flush_valid_i ),
    .flush_ready_o ( flush_ready_o ),
    .req           ( req_if        ),
    .fill          ( fill_if       ),
    .load_o        ( load          ),
    .load_id_o     ( load_id       ),
    .load_data_o   ( load_data     ),
    .load_resp_o   ( load_resp     ),
    .done_i        ( resp_done     )
  );

  roc_refill i_refill (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .fill            ( fill_if         ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_req_addr_o  ( mem_req_addr_o  ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_data_i  ( mem_rsp_data_i  ),
    .mem_rsp_error_i ( mem_rsp_error_i )
  );

  roc_resp_stage i_resp (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .load_i      ( load        ),
    .load_id_i   ( load_id     ),
    .load_data_i ( load_data   ),
    .load_resp_i ( load_resp   ),
    .done_o      ( resp_done   ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_id_o    ( rsp_id_o    ),
    .rsp_data_o  ( rsp_data_o  ),
    .rsp_resp_o  ( rsp_resp_o  )
  );

endmodule

`default_nettype wire

// ==== verif/roc_mem_model.sv ====
// ##################################################
// Backing memory model for the read-only cache
// Random latency, word pattern, error region
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module roc_mem_model (
  input  wire logic                       clk_i,
  input  wire logic                       rst_i,
  input  wire logic                       req_valid_i,
  output logic                            req_ready_o,
  input  wire logic [roc_pkg::ADDR_W-1:0] req_addr_i,
  output logic                            rsp_valid_o,
  output logic [roc_pkg::DATA_W-1:0]      rsp_data_o,
  output logic                            rsp_error_o
);

  logic                       ready_q = 1'b0;
  logic                       valid_q = 1'b0;
  logic                       busy_q  = 1'b0;
  logic                       error_q = 1'b0;
  logic [roc_pkg::ADDR_W-1:0] addr_q  = '0;
  logic [roc_pkg::DATA_W-1:0] data_q  = '0;
  int unsigned                delay_q = 0;

  always @(posedge clk_i) begin
    if (rst_i) begin
      ready_q <= 1'b0;
      valid_q <= 1'b0;
      busy_q  <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (busy_q) begin
        if (delay_q == 0) begin
          valid_q <= 1'b1;
          data_q  <= 32'(addr_q) ^ 32'h5a5a_0000;
          error_q <= (addr_q >= 16'he000) && (addr_q <= 16'hefff);
          busy_q  <= 1'b0;
        end else begin
          delay_q <= delay_q - 1;
        end
      end else if (req_valid_i && ready_q) begin
        busy_q  <= 1'b1;
        ready_q <= 1'b0;
        addr_q  <= req_addr_i;
        delay_q <= $urandom_range(7, 0);
      end else begin
        // Random back-pressure on the request
        ready_q <= ($urandom_range(3, 0) != 0);
      end
    end
  end

  assign req_ready_o = ready_q;
  assign rsp_valid_o = valid_q;
  assign rsp_data_o  = data_q;
  assign rsp_error_o = error_q;

endmodule

`default_nettype wire

// ==== verif/tb_roc_top.sv ====
// ##################################################
// Testbench for the read-only cache subsystem
// Reference model of tags, window and memory traffic
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module tb_roc_top;

  localparam int unsigned WAIT_LIMIT = 200;

  logic                           clk_i = 1'b0;
  logic                           rst_i;
  logic                           req_valid_i;
  logic                           req_ready_o;
  logic [roc_pkg::ADDR_W-1:0]     req_addr_i;
  logic [roc_pkg::ID_W-1:0]       req_id_i;
  logic                           rsp_valid_o;
  logic                           rsp_ready_i;
  logic [roc_pkg::ID_W-1:0]       rsp_id_o;
  logic [roc_pkg::DATA_W-1:0]     rsp_data_o;
  roc_pkg::resp_e                 rsp_resp_o;
  logic                           mem_req_valid_o;
  logic                           mem_req_ready_i;
  logic [roc_pkg::ADDR_W-1:0]     mem_req_addr_o;
  logic                           mem_rsp_valid_i;
  logic [roc_pkg::DATA_W-1:0]     mem_rsp_data_i;
  logic                           mem_rsp_error_i;
  logic [roc_pkg::ADDR_W-1:0]     win_start_i;
  logic [roc_pkg::ADDR_W-1:0]     win_end_i;
  logic                           flush_valid_i;
  logic                           flush_ready_o;

  // Reference model state
  logic [roc_pkg::TAG_W-1:0]      shadow_tag [roc_pkg::LINE_COUNT];
  logic [roc_pkg::LINE_COUNT-1:0] shadow_valid;
  logic [roc_pkg::ADDR_W-1:0]     win_lo;
  logic [roc_pkg::ADDR_W-1:0]     win_hi;
  int unsigned                    mem_req_count;
  int unsigned                    value_errors;
  int unsigned                    protocol_errors;
  bit                             timed_out;

  always #50 clk_i = ~clk_i;

  roc_top dut (.*);

  roc_mem_model mem_model (
    .clk_i       ( clk_i           ),
    .rst_i       ( rst_i           ),
    .req_valid_i ( mem_req_valid_o ),
    .req_ready_o ( mem_req_ready_i ),
    .req_addr_i  ( mem_req_addr_o  ),
    .rsp_valid_o ( mem_rsp_valid_i ),
    .rsp_data_o  ( mem_rsp_data_i  ),
    .rsp_error_o ( mem_rsp_error_i )
  );

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      protocol_errors++;
      $display("Protocol failure at %0t: %s", $time, what);
    end
  endtask

  task automatic report_timeout(input string what);
    protocol_errors++;
    timed_out = 1'b1;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  task automatic set_window(input logic [15:0] lo, input logic [15:0] hi);
    win_lo = lo;
    win_hi = hi;
    win_start_i <= lo;
    win_end_i   <= hi;
  endtask

  task automatic flush_cache;
    int unsigned cycles;
    if (timed_out) return;
    flush_valid_i <= 1'b1;
    cycles = 0;
    @(posedge clk_i);
    while (!flush_ready_o && !timed_out) begin
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("flush_ready_o");
      else @(posedge clk_i);
    end
    flush_valid_i <= 1'b0;
    shadow_valid = '0;
  endtask

  // One read from request to response handshake
  task automatic read_check(input logic [15:0] addr, input logic [3:0] id);
    logic [15:0]               word_addr;
    logic [3:0]                idx;
    logic [roc_pkg::TAG_W-1:0] tag;
    roc_pkg::route_e           route;
    roc_pkg::resp_e            exp_resp;
    bit                        hit, mem_err, held, done, mem_stalled;
    int unsigned               cycles, mem_before, mem_req_at, mem_rsp_at;
    logic [3:0]                held_id;
    logic [31:0]               held_data;
    logic [1:0]                held_resp;
    if (timed_out) return;
    word_addr = {addr[15:roc_pkg::OFFSET_W], 2'b00};
    idx = addr[roc_pkg::OFFSET_W +: roc_pkg::INDEX_W];
    tag = addr[roc_pkg::ADDR_W-1 -: roc_pkg::TAG_W];
    if (addr >= 16'hf000) route = roc_pkg::ROUTE_ERROR;
    else if (addr >= win_lo && addr <= win_hi) route = roc_pkg::ROUTE_CACHE;
    else route = roc_pkg::ROUTE_BYPASS;
    hit = (route == roc_pkg::ROUTE_CACHE) && shadow_valid[idx] && (shadow_tag[idx] == tag);
    mem_err = (word_addr >= 16'he000) && (word_addr <= 16'hefff);
    if (route == roc_pkg::ROUTE_ERROR) exp_resp = roc_pkg::RESP_DECERR;
    else if (!hit && mem_err) exp_resp = roc_pkg::RESP_SLVERR;
    else exp_resp = roc_pkg::RESP_OKAY;

    req_valid_i <= 1'b1;
    req_addr_i  <= addr;
    req_id_i    <= id;
    cycles = 0;
    @(posedge clk_i);
    while (!req_ready_o && !timed_out) begin
      cycles++;
      if (cycles > WAIT_LIMIT) report_timeout("req_ready_o");
      else @(posedge clk_i);
    end
    if (timed_out) return;
    req_valid_i <= 1'b0;
    mem_before = mem_req_count;
    {cycles, mem_req_at, mem_rsp_at, held, done, mem_stalled} = '0;

    while (!done && !timed_out) begin
      @(posedge clk_i);
      cycles++;
      check_true(!req_ready_o, "req_ready_o high while a request is in flight");
      // Lookup has left idle once the arrival cycle is over
      if (cycles > 1) begin
        check_true(!flush_ready_o, "flush_ready_o high while lookup is busy");
      end
      if (mem_stalled) check_true(mem_req_valid_o, "mem_req_valid_o dropped under back-pressure");
      mem_stalled = mem_req_valid_o && !mem_req_ready_i;
      if (mem_req_valid_o && mem_req_at == 0) mem_req_at = cycles;
      if (mem_req_valid_o && mem_req_ready_i) begin
        mem_req_count++;
        check_value("mem_req_addr_o", mem_req_addr_o, word_addr);
      end
      if (mem_rsp_valid_i) mem_rsp_at = cycles;
      if (rsp_valid_o && !held) begin
        held      = 1'b1;
        held_id   = rsp_id_o;
        held_data = rsp_data_o;
        held_resp = rsp_resp_o;
        // Hit and decode error answer one cycle after acceptance
        if (hit || route == roc_pkg::ROUTE_ERROR) begin
          check_true(cycles == 2, "rsp_valid_o did not rise one cycle after acceptance");
        end else begin
          check_true(mem_rsp_at != 0 && cycles == mem_rsp_at + 1,
                     "rsp_valid_o did not rise one cycle after the memory response");
        end
      end else if (rsp_valid_o) begin
        check_value("rsp_id_o", rsp_id_o, held_id);
        check_value("rsp_data_o", rsp_data_o, held_data);
        check_value("rsp_resp_o", rsp_resp_o, held_resp);
      end else begin
        check_true(!held, "rsp_valid_o dropped before the handshake");
      end
      done = rsp_valid_o && rsp_ready_i;
      if (!done && cycles > WAIT_LIMIT) report_timeout("the response handshake");
      rsp_ready_i <= ($urandom_range(1, 0) == 1);
    end
    if (timed_out) return;

    check_value("rsp_id_o", rsp_id_o, id);
    check_value("rsp_resp_o", rsp_resp_o, exp_resp);
    if (exp_resp == roc_pkg::RESP_OKAY) begin
      check_value("rsp_data_o", rsp_data_o, 32'(word_addr) ^ 32'h5a5a_0000);
    end else if (exp_resp == roc_pkg::RESP_DECERR) begin
      check_value("rsp_data_o", rsp_data_o, 32'h0);
    end
    check_value("mem_req_valid_o count", mem_req_count - mem_before,
                (hit || route == roc_pkg::ROUTE_ERROR) ? 0 : 1);
    if (!hit && route != roc_pkg::ROUTE_ERROR) begin
      check_true(mem_req_at == 2, "mem_req_valid_o did not rise one cycle after acceptance");
    end
    if (route == roc_pkg::ROUTE_CACHE && !hit && !mem_err) begin
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = tag;
    end
    @(posedge clk_i);
    check_true(req_ready_o, "req_ready_o not high after the response handshake");
  endtask

  initial begin
    logic [15:0] addr;
    int unsigned sel;
    void'($urandom(32'hd75e_d6ee));
    {value_errors, protocol_errors, mem_req_count} = '0;
    timed_out     = 1'b0;
    shadow_valid  = '0;
    rst_i         = 1'b1;
    req_valid_i   = 1'b0;
    req_addr_i    = '0;
    req_id_i      = '0;
    rsp_ready_i   = 1'b0;
    flush_valid_i = 1'b0;
    set_window(16'h1000, 16'h1fff);
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    check_true(!req_ready_o, "req_ready_o high in the first cycle after reset");
    check_true(!rsp_valid_o && !mem_req_valid_o, "valid output high after reset");
    check_true(flush_ready_o, "flush_ready_o low after reset");

    // Miss, hit, conflict and refill again
    read_check(16'h1040, 4'h1);
    read_check(16'h1040, 4'h2);
    read_check(16'h1042, 4'h3);
    read_check(16'h1440, 4'h4);
    read_check(16'h1040, 4'h5);
    // Bypass never fills
    read_check(16'h3000, 4'h6);
    read_check(16'h3000, 4'h7);
    read_check(16'hf000, 4'h8);
    read_check(16'hfffc, 4'h9);
    // Memory error inside the window is not cached
    set_window(16'he000, 16'he0ff);
    read_check(16'he010, 4'ha);
    read_check(16'he010, 4'hb);
    set_window(16'h1000, 16'h1fff);
    read_check(16'h1080, 4'hc);
    read_check(16'h1080, 4'hd);
    flush_cache();
    read_check(16'h1080, 4'he);

    for (int n = 0; n < 200; n++) begin
      sel = $urandom_range(9, 0);
      if (sel < 6) addr = 16'h1000 | 16'($urandom_range(47, 0) << 2) | 16'($urandom_range(3, 0));
      else if (sel < 8) addr = 16'h4000 | 16'($urandom_range(16'h0fff, 0));
      else if (sel == 8) addr = 16'he000 | 16'($urandom_range(16'h0fff, 0));
      else addr = 16'hf000 | 16'($urandom_range(16'h0fff, 0));
      read_check(addr, 4'(n));
      if ($urandom_range(19, 0) == 0) flush_cache();
    end

    $display("Error counts: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== roc.f ====
hdl/roc_pkg.sv
hdl/roc_req_if.sv
hdl/roc_fill_if.sv
hdl/roc_addr_decode.sv
hdl/roc_lookup.sv
hdl/roc_refill.sv
hdl/roc_resp_stage.sv
hdl/roc_top.sv
verif/roc_mem_model.sv
verif/tb_roc_top.sv
